/* Bender.yml */
package:
  name: host_if

sources:
  - files:
      - common/host_if_pkg.sv
      - common/xfer_if.sv
      - design/sync_fifo.sv
      - design/xfer_arbiter.sv
      - inbound/inbound_path.sv
      - outbound/outbound_path.sv
      - design/host_if.sv
  - target: test
    files:
      - dv/host_if_tb.sv

/* common/host_if_pkg.sv */
// Shared widths and types for the host link; kind codes must match the host software
`default_nettype none

package host_if_pkg;

    localparam int word_w = 16;  // Host and buffer word
    localparam int addr_w = 10;  // Global buffer address

    // Transfer kinds, codes fixed by the host protocol
    typedef enum logic [3:0] {
        kind_cfg     = 4'd0,
        kind_act     = 4'd2,
        kind_flg_act = 4'd4,
        kind_wei     = 4'd6,
        kind_flg_wei = 4'd8,
        kind_flg_ofm = 4'd10,
        kind_ofm     = 4'd11
    } xfer_kind_t;

    typedef logic [word_w-1:0] data_word_t;

    // Receive FIFO entry
    typedef struct packed {
        logic       last;  // Closes the transfer
        data_word_t data;
    } in_word_t;

    // Host to chip direction
    function automatic logic is_inbound(input xfer_kind_t kind);
        return !(kind == kind_flg_ofm || kind == kind_ofm);
    endfunction

endpackage

`default_nettype wire

/* common/xfer_if.sv */
// Grant and completion between arbiter and paths; kind is stable from start until done
`default_nettype none
`timescale 1ns/100ps

interface xfer_if;
    import host_if_pkg::*;

    logic       start;     // One-cycle grant pulse
    xfer_kind_t kind;      // Granted kind
    logic       in_done;   // Inbound transfer finished
    logic       out_done;  // Outbound transfer finished

    modport arbiter (
        output start, kind,
        input  in_done, out_done
    );

    modport inbound (
        input  start, kind,
        output in_done
    );

    modport outbound (
        input  start, kind,
        output out_done
    );

endinterface

`default_nettype wire

/* design/host_if.sv */
// Host link top; host ports run in the chip clock, and the global buffers are outside
`default_nettype none
`timescale 1ns/100ps

module host_if #(
    parameter int FIFO_DEPTH      = 16,
    parameter int NEAR_FULL_LEVEL = 12,
    parameter int OFM_BURST       = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // Host side
    input  logic                           host_wr,
    input  host_if_pkg::data_word_t        host_wdata,
    input  logic                           host_last,
    input  logic                           host_rd,
    output host_if_pkg::data_word_t        host_rdata,
    output logic                           host_rvalid,
    output logic                           host_req,
    output host_if_pkg::xfer_kind_t        host_kind,
    output logic                           near_full,
    // Core requests and address clears
    input  logic                           cfg_req,
    input  logic                           load_wei,
    input  logic                           load_act,
    input  logic                           ofm_ready,
    input  logic                           reset_wei,
    input  logic                           reset_act,
    input  logic                           reset_ofm,
    // Buffer write port
    output logic                           gbf_wr_en,
    output host_if_pkg::xfer_kind_t        gbf_wr_kind,
    output logic [host_if_pkg::addr_w-1:0] gbf_wr_addr,
    output host_if_pkg::data_word_t        gbf_wr_data,
    // Buffer read port
    output logic                           gbf_rd_en,
    output host_if_pkg::xfer_kind_t        gbf_rd_kind,
    output logic [host_if_pkg::addr_w-1:0] gbf_rd_addr,
    input  host_if_pkg::data_word_t        gbf_rd_data,
    // Configuration words
    output logic                           cfg_valid,
    output host_if_pkg::data_word_t        cfg_data
);

    xfer_if xfer ();

    xfer_arbiter arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_req   (cfg_req),
        .load_wei  (load_wei),
        .load_act  (load_act),
        .ofm_ready (ofm_ready),
        .xfer      (xfer.arbiter),
        .host_req  (host_req),
        .host_kind (host_kind)
    );

    inbound_path #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .NEAR_FULL_LEVEL (NEAR_FULL_LEVEL)
    ) inbound_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_wr     (host_wr),
        .host_last   (host_last),
        .reset_wei   (reset_wei),
        .reset_act   (reset_act),
        .host_wdata  (host_wdata),
        .xfer        (xfer.inbound),
        .near_full   (near_full),
        .gbf_wr_en   (gbf_wr_en),
        .cfg_valid   (cfg_valid),
        .gbf_wr_kind (gbf_wr_kind),
        .gbf_wr_addr (gbf_wr_addr),
        .gbf_wr_data (gbf_wr_data),
        .cfg_data    (cfg_data)
    );

    outbound_path #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .OFM_BURST  (OFM_BURST)
    ) outbound_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_rd     (host_rd),
        .reset_ofm   (reset_ofm),
        .gbf_rd_data (gbf_rd_data),
        .xfer        (xfer.outbound),
        .gbf_rd_en   (gbf_rd_en),
        .host_rvalid (host_rvalid),
        .gbf_rd_kind (gbf_rd_kind),
        .gbf_rd_addr (gbf_rd_addr),
        .host_rdata  (host_rdata)
    );

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
// Single-clock FIFO with the head visible on rdata; FIFO_DEPTH >= 2, pushes while full are lost
`default_nettype none
`timescale 1ns/100ps

module sync_fifo #(
    parameter int  FIFO_DEPTH = 16,
    parameter type payload_t  = logic [7:0]
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              push,
    input  logic                              pop,
    input  payload_t                          wdata,
    output payload_t                          rdata,
    output logic [$clog2(FIFO_DEPTH + 1)-1:0] count,
    output logic                              empty,
    output logic                              full
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == FIFO_DEPTH);
    assign rdata   = mem[rd_ptr];  // No read latency

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/xfer_arbiter.sv */
// One transfer at a time; requests arriving during a grant stay pending, repeats merge
`default_nettype none
`timescale 1ns/100ps

module xfer_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_req,
    input  logic                    load_wei,
    input  logic                    load_act,
    input  logic                    ofm_ready,
    xfer_if.arbiter                 xfer,
    output logic                    host_req,
    output host_if_pkg::xfer_kind_t host_kind
);
    import host_if_pkg::*;

    localparam int N_KIND = 7;

    // Index 0 wins
    localparam xfer_kind_t grant_order [N_KIND] = '{
        kind_cfg, kind_flg_wei, kind_wei, kind_flg_act, kind_act, kind_flg_ofm, kind_ofm
    };

    logic [N_KIND-1:0] pend;
    logic [N_KIND-1:0] req_set;
    logic [N_KIND-1:0] pick;
    logic [N_KIND-1:0] grant;
    xfer_kind_t        pick_kind;
    logic              done;

    // ========================================================================
    // Request collection and selection
    // ========================================================================
    // A load asks for the flag stream first, then the data
    assign req_set = {ofm_ready, ofm_ready, load_act, load_act, load_wei, load_wei, cfg_req};

    always_comb begin
        pick      = '0;
        pick_kind = kind_cfg;
        for (int i = N_KIND - 1; i >= 0; i--) begin
            if (pend[i]) begin
                pick      = '0;
                pick[i]   = 1'b1;
                pick_kind = grant_order[i];
            end
        end
    end

    assign grant = (!host_req && |pend) ? pick : '0;  // host_req doubles as busy

    // Completion comes from whichever path owns the kind
    assign done = is_inbound(xfer.kind) ? xfer.in_done : xfer.out_done;

    // ========================================================================
    // Grant register
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend       <= '0;
            host_req   <= 1'b0;
            xfer.start <= 1'b0;
            xfer.kind  <= kind_cfg;
        end else begin
            pend       <= (pend | req_set) & ~grant;
            xfer.start <= |grant;
            if (|grant) begin
                host_req  <= 1'b1;
                xfer.kind <= pick_kind;
            end else if (host_req && done) begin
                host_req <= 1'b0;  // Low the cycle after done
            end
        end
    end

    assign host_kind = xfer.kind;

endmodule

`default_nettype wire

/* dv/host_if_stimulus.txt */
# Columns: command, then up to four hex arguments; model a sets read data = kind * a + address
# req mask(cfg,wei,act,ofm) | rst mask(wei,act,ofm) | send n first | grant kind | expw kind n addr data
# expc n data | read n gap first | nf level | done waits for host_req low | test name
model 100
nf 0
test cfg_load
req 1
send 3 c001
grant 0
expc 3 c001
done
test wei_load
req 2
send 4 1000
send 6 2000
grant 8
expw 8 4 0 1000
grant 6
expw 6 6 0 2000
done
test act_continue
req 4
send 3 4000
send 2 5000
grant 4
expw 4 3 0 4000
grant 2
expw 2 2 0 5000
done
req 4
send 2 4100
send 3 5100
grant 4
expw 4 2 3 4100
grant 2
expw 2 3 2 5100
done
rst 2
test ofm_read
req 8
grant a
grant b
req 8
grant a
read 8 0 a00
read 8 0 b00
read 8 3 a08
grant b
read 8 2 b08
done
rst 4
test priority
send 3 c101
send 4 4200
nf 0
send 6 5200
nf 1
req d
grant 0
expc 3 c101
grant 4
expw 4 4 0 4200
grant 2
expw 2 6 0 5200
nf 0
grant a
grant b
read 8 0 a00
read 8 0 b00
done

/* dv/host_if_tb.sv */
// Stimulus file assumes FIFO_DEPTH 16, NEAR_FULL_LEVEL 12 and OFM_BURST 8
`default_nettype none
`timescale 1ns/100ps

module host_if_tb;
    import host_if_pkg::*;

    localparam int TIMEOUT    = 200;  // Cycles per wait
    localparam int LOG_GRANT  = 0;
    localparam int LOG_WRITE  = 1;
    localparam int LOG_CFG    = 2;

    logic              clk;
    logic              rst_n;
    logic              host_wr;
    data_word_t        host_wdata;
    logic              host_last;
    logic              host_rd;
    data_word_t        host_rdata;
    logic              host_rvalid;
    logic              host_req;
    xfer_kind_t        host_kind;
    logic              near_full;
    logic              cfg_req;
    logic              load_wei;
    logic              load_act;
    logic              ofm_ready;
    logic              reset_wei;
    logic              reset_act;
    logic              reset_ofm;
    logic              gbf_wr_en;
    xfer_kind_t        gbf_wr_kind;
    logic [addr_w-1:0] gbf_wr_addr;
    data_word_t        gbf_wr_data;
    logic              gbf_rd_en;
    xfer_kind_t        gbf_rd_kind;
    logic [addr_w-1:0] gbf_rd_addr;
    data_word_t        gbf_rd_data;
    logic              cfg_valid;
    data_word_t        cfg_data;

    // Observed traffic, drained by the command loop
    xfer_kind_t        grant_q [$];
    xfer_kind_t        wr_kind_q [$];
    logic [addr_w-1:0] wr_addr_q [$];
    data_word_t        wr_data_q [$];
    data_word_t        cfg_q [$];

    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;
    int          rule_mul     = 256;  // Overwritten by the model command
    string       test_name    = "none";
    logic        req_seen;
    xfer_kind_t  held_kind;
    int          fd;
    int          code;
    string       line;
    string       cmd;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;

    host_if #(
        .FIFO_DEPTH      (16),
        .NEAR_FULL_LEVEL (12),
        .OFM_BURST       (8)
    ) host_if_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_wr     (host_wr),
        .host_wdata  (host_wdata),
        .host_last   (host_last),
        .host_rd     (host_rd),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid),
        .host_req    (host_req),
        .host_kind   (host_kind),
        .near_full   (near_full),
        .cfg_req     (cfg_req),
        .load_wei    (load_wei),
        .load_act    (load_act),
        .ofm_ready   (ofm_ready),
        .reset_wei   (reset_wei),
        .reset_act   (reset_act),
        .reset_ofm   (reset_ofm),
        .gbf_wr_en   (gbf_wr_en),
        .gbf_wr_kind (gbf_wr_kind),
        .gbf_wr_addr (gbf_wr_addr),
        .gbf_wr_data (gbf_wr_data),
        .gbf_rd_en   (gbf_rd_en),
        .gbf_rd_kind (gbf_rd_kind),
        .gbf_rd_addr (gbf_rd_addr),
        .gbf_rd_data (gbf_rd_data),
        .cfg_valid   (cfg_valid),
        .cfg_data    (cfg_data)
    );

    always #20 clk = ~clk;  // 40 ns period

    // ========================================================================
    // Buffer model and traffic monitor
    // ========================================================================
    always @(posedge clk) begin
        if (gbf_rd_en) begin
            gbf_rd_data <= data_word_t'(rule_mul * int'(gbf_rd_kind) + int'(gbf_rd_addr));
        end
    end

    // Sampled mid-cycle where outputs have settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (gbf_wr_en) begin
                wr_kind_q.push_back(gbf_wr_kind);
                wr_addr_q.push_back(gbf_wr_addr);
                wr_data_q.push_back(gbf_wr_data);
                if (gbf_wr_kind == kind_cfg) begin
                    $display("ERROR %s: buffer write during a configuration transfer", test_name);
                    fail_cnt++;
                end
            end
            if (cfg_valid) begin
                cfg_q.push_back(cfg_data);
            end
            if (host_req && !req_seen) begin
                grant_q.push_back(host_kind);  // New grant
            end else if (host_req && host_kind != held_kind) begin
                $display("ERROR %s: host_kind changed while host_req was high", test_name);
                fail_cnt++;
            end
            req_seen  = host_req;
            held_kind = host_kind;
        end
    end

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_kind(input string name, input xfer_kind_t exp, input xfer_kind_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected kind %0d, actual kind %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] exp,
                              input logic [addr_w-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected address %h, actual address %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    // ========================================================================
    // Drivers and waits
    // ========================================================================
    task automatic pulse_requests(input logic [3:0] mask);
        @(posedge clk);
        cfg_req   <= mask[0];
        load_wei  <= mask[1];
        load_act  <= mask[2];
        ofm_ready <= mask[3];
        @(posedge clk);
        {ofm_ready, load_act, load_wei, cfg_req} <= 4'b0000;
    endtask

    task automatic pulse_clears(input logic [2:0] mask);
        @(posedge clk);
        reset_wei <= mask[0];
        reset_act <= mask[1];
        reset_ofm <= mask[2];
        @(posedge clk);
        {reset_ofm, reset_act, reset_wei} <= 3'b000;
    endtask

    task automatic send_words(input int n, input data_word_t first);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            host_wr    <= 1'b1;
            host_wdata <= first + data_word_t'(i);
            host_last  <= (i == n - 1);  // Closes the transfer
        end
        @(posedge clk);
        host_wr   <= 1'b0;
        host_last <= 1'b0;
    endtask

    function automatic int log_size(input int which);
        case (which)
            LOG_GRANT: return grant_q.size();
            LOG_WRITE: return wr_data_q.size();
            default:   return cfg_q.size();
        endcase
    endfunction

    task automatic wait_for_log(input int which, input string what, output logic ok);
        int cycles;
        cycles = 0;
        while (log_size(which) == 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (log_size(which) != 0);
        if (!ok) begin
            $display("ERROR %s: timed out waiting for %s", test_name, what);
            fail_cnt++;
        end
    endtask

    task automatic expect_grant(input xfer_kind_t kind);
        logic ok;
        wait_for_log(LOG_GRANT, "a grant", ok);
        if (ok) begin
            check_kind(test_name, kind, grant_q.pop_front());
        end
    endtask

    task automatic expect_writes(input xfer_kind_t kind, input int n,
                                 input logic [addr_w-1:0] addr0, input data_word_t data0);
        logic ok;
        for (int i = 0; i < n; i++) begin
            wait_for_log(LOG_WRITE, "a buffer write", ok);
            if (ok) begin
                check_kind(test_name, kind, wr_kind_q.pop_front());
                check_addr(test_name, addr0 + addr_w'(i), wr_addr_q.pop_front());
                check_word(test_name, data0 + data_word_t'(i), wr_data_q.pop_front());
            end
        end
    endtask

    task automatic expect_cfg(input int n, input data_word_t data0);
        logic ok;
        for (int i = 0; i < n; i++) begin
            wait_for_log(LOG_CFG, "a configuration word", ok);
            if (ok) begin
                check_word(test_name, data0 + data_word_t'(i), cfg_q.pop_front());
            end
        end
    endtask

    // Retries a read on an empty FIFO until a word comes back
    task automatic host_read(input int n, input int gap, input data_word_t first);
        int   tries;
        logic got;
        for (int i = 0; i < n; i++) begin
            repeat (gap) @(posedge clk);
            got   = 1'b0;
            tries = 0;
            while (!got && tries < TIMEOUT) begin
                @(posedge clk);
                host_rd <= 1'b1;
                @(posedge clk);
                host_rd <= 1'b0;
                @(negedge clk);
                got = host_rvalid;
                tries++;
            end
            if (got) begin
                check_word(test_name, first + data_word_t'(i), host_rdata);
            end else begin
                $display("ERROR %s: timed out waiting for host_rvalid", test_name);
                fail_cnt++;
            end
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (host_req && cycles < TIMEOUT);
        if (host_req) begin
            $display("ERROR %s: timed out waiting for host_req to fall", test_name);
            fail_cnt++;
        end
    endtask

    task automatic check_near_full(input logic exp);
        @(negedge clk);
        if (near_full !== exp) begin
            $display("MISMATCH %s: expected near_full %b, actual %b", test_name, exp, near_full);
            mismatch_cnt++;
        end
    endtask

    // ========================================================================
    // Command loop
    // ========================================================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        host_wr     = 1'b0;
        host_wdata  = '0;
        host_last   = 1'b0;
        host_rd     = 1'b0;
        cfg_req     = 1'b0;
        load_wei    = 1'b0;
        load_act    = 1'b0;
        ofm_ready   = 1'b0;
        reset_wei   = 1'b0;
        reset_act   = 1'b0;
        reset_ofm   = 1'b0;
        gbf_rd_data = '0;
        req_seen    = 1'b0;
        held_kind   = kind_cfg;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("dv/host_if_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%s %h %h %h %h", cmd, a0, a1, a2, a3);
                    case (cmd)
                        "test":  code = $sscanf(line, "%s %s", cmd, test_name);
                        "model": rule_mul = a0;
                        "req":   pulse_requests(a0[3:0]);
                        "rst":   pulse_clears(a0[2:0]);
                        "send":  send_words(a0, data_word_t'(a1));
                        "grant": expect_grant(xfer_kind_t'(a0[3:0]));
                        "expw":  expect_writes(xfer_kind_t'(a0[3:0]), a1, addr_w'(a2),
                                               data_word_t'(a3));
                        "expc":  expect_cfg(a0, data_word_t'(a1));
                        "read":  host_read(a0, a1, data_word_t'(a2));
                        "nf":    check_near_full(a0[0]);
                        "done":  wait_idle();
                        default: begin
                            $display("ERROR: unknown stimulus command %s", cmd);
                            fail_cnt++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        // Anything left over was never expected
        repeat (4) @(posedge clk);
        if (grant_q.size() != 0 || wr_data_q.size() != 0 || cfg_q.size() != 0) begin
            $display("ERROR: unexpected traffic, %0d grants, %0d writes, %0d config words",
                     grant_q.size(), wr_data_q.size(), cfg_q.size());
            fail_cnt++;
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* host_if.f */
common/host_if_pkg.sv
common/xfer_if.sv
design/sync_fifo.sv
design/xfer_arbiter.sv
inbound/inbound_path.sv
outbound/outbound_path.sv
design/host_if.sv
dv/host_if_tb.sv

/* inbound/inbound_path.sv */
// Host to buffer path; words sent before a grant wait in the FIFO, address counters wrap silently
`default_nettype none
`timescale 1ns/100ps

module inbound_path #(
    parameter int FIFO_DEPTH      = 16,
    parameter int NEAR_FULL_LEVEL = 12
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               host_wr,
    input  logic                               host_last,
    input  logic                               reset_wei,
    input  logic                               reset_act,
    input  host_if_pkg::data_word_t            host_wdata,
    xfer_if.inbound                            xfer,
    output logic                               near_full,
    output logic                               gbf_wr_en,
    output logic                               cfg_valid,
    output host_if_pkg::xfer_kind_t            gbf_wr_kind,
    output logic [host_if_pkg::addr_w-1:0]     gbf_wr_addr,
    output host_if_pkg::data_word_t            gbf_wr_data,
    output host_if_pkg::data_word_t            cfg_data
);
    import host_if_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    in_word_t          rx_word;
    in_word_t          head;
    logic [CNT_W-1:0]  fill;
    logic              rx_empty;
    logic              active;
    logic              pop;
    logic              is_cfg;
    logic [1:0]        cnt_sel;
    logic [3:0]        cnt_clr;
    logic [addr_w-1:0] wr_addr [4];

    // ========================================================================
    // Receive FIFO
    // ========================================================================
    assign rx_word = '{last: host_last, data: host_wdata};

    sync_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (in_word_t)
    ) rx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (host_wr),
        .pop   (pop),
        .wdata (rx_word),
        .rdata (head),
        .count (fill),
        .empty (rx_empty),
        .full  ()
    );

    assign near_full = (fill >= NEAR_FULL_LEVEL);

    // ========================================================================
    // Transfer control and steering
    // ========================================================================
    assign pop    = active && !rx_empty;  // One word per cycle
    assign is_cfg = (xfer.kind == kind_cfg);

    assign cfg_valid   = pop && is_cfg;
    assign cfg_data    = head.data;
    assign gbf_wr_en   = pop && !is_cfg;
    assign gbf_wr_kind = xfer.kind;
    assign gbf_wr_data = head.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            xfer.in_done <= 1'b0;
        end else begin
            xfer.in_done <= pop && head.last;
            if (xfer.start && is_inbound(xfer.kind)) begin
                active <= 1'b1;
            end else if (pop && head.last) begin
                active <= 1'b0;
            end
        end
    end

    // ========================================================================
    // Per-kind write address counters
    // ========================================================================
    always_comb begin
        case (xfer.kind)
            kind_flg_wei: cnt_sel = 2'd0;
            kind_wei:     cnt_sel = 2'd1;
            kind_flg_act: cnt_sel = 2'd2;
            default:      cnt_sel = 2'd3;  // act
        endcase
    end

    assign cnt_clr     = {reset_act, reset_act, reset_wei, reset_wei};
    assign gbf_wr_addr = wr_addr[cnt_sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                wr_addr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (cnt_clr[i]) begin
                    wr_addr[i] <= '0;  // Clear beats a same-cycle write
                end else if (gbf_wr_en && cnt_sel == i) begin
                    wr_addr[i] <= wr_addr[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* outbound/outbound_path.sv */
// Buffer to host path; buffer read data must follow gbf_rd_en by exactly one cycle
`default_nettype none
`timescale 1ns/100ps

module outbound_path #(
    parameter int FIFO_DEPTH = 16,
    parameter int OFM_BURST  = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           host_rd,
    input  logic                           reset_ofm,
    input  host_if_pkg::data_word_t        gbf_rd_data,
    xfer_if.outbound                       xfer,
    output logic                           gbf_rd_en,
    output logic                           host_rvalid,
    output host_if_pkg::xfer_kind_t        gbf_rd_kind,
    output logic [host_if_pkg::addr_w-1:0] gbf_rd_addr,
    output host_if_pkg::data_word_t        host_rdata
);
    import host_if_pkg::*;

    localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
    localparam int BURST_W = $clog2(OFM_BURST + 1);

    logic               active;
    logic [BURST_W-1:0] issued;
    logic               last_rd;
    logic               rd_en_d;    // Read in flight
    logic               last_rd_d;
    logic [CNT_W-1:0]   fill;
    logic               tx_empty;
    logic               tx_pop;
    data_word_t         head;
    logic               cnt_sel;
    logic [addr_w-1:0]  rd_addr [2];

    // ========================================================================
    // Read sequencing
    // ========================================================================
    // Stall while the FIFO could not take the returning word
    assign gbf_rd_en   = active && (int'(fill) + int'(rd_en_d) < FIFO_DEPTH);
    assign last_rd     = gbf_rd_en && (issued == BURST_W'(OFM_BURST - 1));
    assign gbf_rd_kind = xfer.kind;
    assign cnt_sel     = (xfer.kind == kind_ofm);  // 0 flg_ofm, 1 ofm
    assign gbf_rd_addr = rd_addr[cnt_sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active        <= 1'b0;
            issued        <= '0;
            rd_en_d       <= 1'b0;
            last_rd_d     <= 1'b0;
            xfer.out_done <= 1'b0;
        end else begin
            rd_en_d       <= gbf_rd_en;
            last_rd_d     <= last_rd;
            xfer.out_done <= last_rd_d;  // After the final push
            if (xfer.start && !is_inbound(xfer.kind)) begin
                active <= 1'b1;
                issued <= '0;
            end else if (gbf_rd_en) begin
                issued <= issued + 1'b1;
                if (last_rd) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Read addresses carry over between bursts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr[0] <= '0;
            rd_addr[1] <= '0;
        end else if (reset_ofm) begin
            rd_addr[0] <= '0;
            rd_addr[1] <= '0;
        end else if (gbf_rd_en) begin
            rd_addr[cnt_sel] <= rd_addr[cnt_sel] + 1'b1;
        end
    end

    // ========================================================================
    // Send FIFO and host read port
    // ========================================================================
    sync_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (data_word_t)
    ) tx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rd_en_d),
        .pop   (tx_pop),
        .wdata (gbf_rd_data),
        .rdata (head),
        .count (fill),
        .empty (tx_empty),
        .full  ()
    );

    assign tx_pop = host_rd && !tx_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= tx_pop;  // Low for a read on empty
        end
    end

    always_ff @(posedge clk) begin
        if (tx_pop) begin
            host_rdata <= head;
        end
    end

endmodule

`default_nettype wire
